// ==== design/csr_pkg.sv ====
/*
 * Shared types of the machine-mode CSR block: data and address types,
 * the CSR operation enum, CSR addresses, bit positions and the misa value.
 */
package csr_pkg;

  // --------------------
  // types
  // --------------------
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // bit 5 marks an interrupt, bits 4:0 hold the code
  typedef logic [5:0]  exc_cause_t;
  typedef logic [14:0] irq_fast_t;

  typedef enum logic [1:0] {
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  // --------------------
  // csr addresses
  // --------------------
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MISA          = 12'h301;
  localparam csr_addr_t CSR_MIE           = 12'h304;
  localparam csr_addr_t CSR_MTVEC         = 12'h305;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_MCAUSE        = 12'h342;
  localparam csr_addr_t CSR_MTVAL         = 12'h343;
  localparam csr_addr_t CSR_MIP           = 12'h344;
  localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;
  localparam csr_addr_t CSR_MHARTID       = 12'hF14;

  // bit positions in mstatus, mie and mip
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSIX_BIT         = 3;
  localparam int unsigned MTIX_BIT         = 7;
  localparam int unsigned MEIX_BIT         = 11;
  localparam int unsigned MFIX_LOW         = 16;
  localparam int unsigned MFIX_HIGH        = 30;

  // rv32ic, mxl = 1 for 32 bit
  localparam csr_data_t MISA_VALUE =
      (32'd1 << 2)     // C
    | (32'd1 << 8)     // I
    | (32'd1 << 30);   // mxl

endpackage

// ==== design/csr_bus_if.sv ====
/*
 * Access bus between the CSR access controller and one register bank.
 */
`timescale 1ns/1ps

interface csr_bus_if
  import csr_pkg::*;
();

  csr_addr_t addr;
  // effective write data, already merged for set and clear
  csr_data_t wdata;
  logic      we;
  csr_data_t rdata;
  // bank owns the address
  logic      hit;

  modport ctrl (output addr, output wdata, output we, input rdata, input hit);
  modport bank (input addr, input wdata, input we, output rdata, output hit);

endinterface

// ==== design/csr_access_ctrl.sv ====
/*
 * CSR access controller: operation decode, read data select,
 * illegal access detection and the write enable for both banks.
 */
`timescale 1ns/1ps

module csr_access_ctrl
  import csr_pkg::*;
(
  input  logic      csr_access_i,
  input  logic      instr_new_i,
  input  csr_addr_t csr_addr_i,
  input  csr_op_e   csr_op_i,
  input  csr_data_t csr_wdata_i,
  input  csr_data_t hart_id_i,
  output csr_data_t csr_rdata_o,
  output logic      illegal_csr_o,
  csr_bus_if.ctrl   trap_bus,
  csr_bus_if.ctrl   perf_bus
);

  csr_data_t wdata_eff;
  logic      any_hit;
  logic      wreq;

  // constant registers answered here, banks by their hit
  always_comb begin
    csr_rdata_o = '0;
    any_hit     = 1'b1;
    if (csr_addr_i == CSR_MHARTID) begin
      csr_rdata_o = hart_id_i;
    end else if (csr_addr_i == CSR_MISA) begin
      csr_rdata_o = MISA_VALUE;
    end else if (trap_bus.hit) begin
      csr_rdata_o = trap_bus.rdata;
    end else if (perf_bus.hit) begin
      csr_rdata_o = perf_bus.rdata;
    end else begin
      any_hit = 1'b0;
    end
  end

  // --------------------
  // operation decode
  // --------------------
  always_comb begin
    wreq      = 1'b1;
    wdata_eff = csr_wdata_i;
    case (csr_op_i)
      CSR_OP_WRITE: wdata_eff = csr_wdata_i;
      CSR_OP_SET:   wdata_eff = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wdata_eff = ~csr_wdata_i & csr_rdata_o;
      default:      wreq      = 1'b0;
    endcase
  end

  // addr[11:10] == 11 marks a read-only csr
  assign illegal_csr_o = csr_access_i &
                         (~any_hit | (wreq & (csr_addr_i[11:10] == 2'b11)));

  assign trap_bus.addr  = csr_addr_i;
  assign trap_bus.wdata = wdata_eff;
  assign trap_bus.we    = csr_access_i & instr_new_i & wreq & ~illegal_csr_o;

  assign perf_bus.addr  = csr_addr_i;
  assign perf_bus.wdata = wdata_eff;
  assign perf_bus.we    = trap_bus.we;

endmodule

// ==== design/trap_csrs.sv ====
/*
 * Trap and interrupt CSRs: mstatus, mie, mip, mepc, mcause, mtval,
 * mtvec and mscratch, with trap entry, mret and the pending flag.
 */
`timescale 1ns/1ps

module trap_csrs
  import csr_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       irq_software_i,
  input  logic       irq_timer_i,
  input  logic       irq_external_i,
  input  irq_fast_t  irq_fast_i,
  input  logic       csr_mtvec_init_i,
  input  csr_data_t  boot_addr_i,
  input  logic       csr_save_cause_i,
  input  logic       csr_save_if_i,
  input  csr_data_t  pc_if_i,
  input  csr_data_t  pc_id_i,
  input  exc_cause_t csr_mcause_i,
  input  csr_data_t  csr_mtval_i,
  input  logic       csr_restore_mret_i,
  output csr_data_t  csr_mtvec_o,
  output csr_data_t  csr_mepc_o,
  output logic       csr_mstatus_mie_o,
  output logic       irq_pending_o,
  csr_bus_if.bank    bus
);

  logic       mstatus_mie_q, mstatus_mie_d;
  logic       mstatus_mpie_q, mstatus_mpie_d;
  logic       mie_sw_q, mie_sw_d;
  logic       mie_tim_q, mie_tim_d;
  logic       mie_ext_q, mie_ext_d;
  irq_fast_t  mie_fast_q, mie_fast_d;
  csr_data_t  mscratch_q, mscratch_d;
  csr_data_t  mepc_q, mepc_d;
  exc_cause_t mcause_q, mcause_d;
  csr_data_t  mtval_q, mtval_d;
  csr_data_t  mtvec_q, mtvec_d;
  csr_data_t  mie_word;
  csr_data_t  mip_word;

  // places the interrupt fields at their mie/mip positions
  function automatic csr_data_t irq_word(logic sw, logic tim, logic ext, irq_fast_t fast);
    csr_data_t w;
    w                     = '0;
    w[MSIX_BIT]           = sw;
    w[MTIX_BIT]           = tim;
    w[MEIX_BIT]           = ext;
    w[MFIX_HIGH:MFIX_LOW] = fast;
    return w;
  endfunction

  assign mie_word = irq_word(mie_sw_q, mie_tim_q, mie_ext_q, mie_fast_q);
  // mip is combinational so a pending line shows at once
  assign mip_word = irq_word(irq_software_i, irq_timer_i, irq_external_i, irq_fast_i) &
                    mie_word;

  // --------------------
  // read side
  // --------------------
  always_comb begin
    bus.rdata = '0;
    bus.hit   = 1'b1;
    case (bus.addr)
      CSR_MSTATUS: begin
        bus.rdata[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        bus.rdata[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      CSR_MIE:      bus.rdata = mie_word;
      CSR_MIP:      bus.rdata = mip_word;
      CSR_MSCRATCH: bus.rdata = mscratch_q;
      CSR_MEPC:     bus.rdata = mepc_q;
      CSR_MCAUSE:   bus.rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MTVAL:    bus.rdata = mtval_q;
      CSR_MTVEC:    bus.rdata = mtvec_q;
      default:      bus.hit   = 1'b0;
    endcase
  end

  // --------------------
  // write side
  // --------------------
  always_comb begin
    mstatus_mie_d  = mstatus_mie_q;
    mstatus_mpie_d = mstatus_mpie_q;
    mie_sw_d       = mie_sw_q;
    mie_tim_d      = mie_tim_q;
    mie_ext_d      = mie_ext_q;
    mie_fast_d     = mie_fast_q;
    mscratch_d     = mscratch_q;
    mepc_d         = mepc_q;
    mcause_d       = mcause_q;
    mtval_d        = mtval_q;
    // vectored mode, base on 256 byte boundary
    mtvec_d        = csr_mtvec_init_i ? {boot_addr_i[31:8], 6'b0, 2'b01} : mtvec_q;

    if (bus.we) begin
      case (bus.addr)
        CSR_MSTATUS: begin
          mstatus_mie_d  = bus.wdata[MSTATUS_MIE_BIT];
          mstatus_mpie_d = bus.wdata[MSTATUS_MPIE_BIT];
        end
        CSR_MIE: begin
          mie_sw_d   = bus.wdata[MSIX_BIT];
          mie_tim_d  = bus.wdata[MTIX_BIT];
          mie_ext_d  = bus.wdata[MEIX_BIT];
          mie_fast_d = bus.wdata[MFIX_HIGH:MFIX_LOW];
        end
        CSR_MSCRATCH: mscratch_d = bus.wdata;
        CSR_MEPC:     mepc_d     = {bus.wdata[31:1], 1'b0};
        CSR_MCAUSE:   mcause_d   = {bus.wdata[31], bus.wdata[4:0]};
        CSR_MTVAL:    mtval_d    = bus.wdata;
        CSR_MTVEC:    mtvec_d    = {bus.wdata[31:8], 6'b0, 2'b01};
        default: ;
      endcase
    end

    // trap entry and mret win over a csr write
    if (csr_save_cause_i) begin
      mepc_d         = csr_save_if_i ? {pc_if_i[31:1], 1'b0} : {pc_id_i[31:1], 1'b0};
      mcause_d       = csr_mcause_i;
      mtval_d        = csr_mtval_i;
      mstatus_mpie_d = mstatus_mie_q;
      mstatus_mie_d  = 1'b0;
    end else if (csr_restore_mret_i) begin
      mstatus_mie_d  = mstatus_mpie_q;
      mstatus_mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b1;
      mie_sw_q       <= 1'b0;
      mie_tim_q      <= 1'b0;
      mie_ext_q      <= 1'b0;
      mie_fast_q     <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mtvec_q        <= 32'h1;
    end else begin
      mstatus_mie_q  <= mstatus_mie_d;
      mstatus_mpie_q <= mstatus_mpie_d;
      mie_sw_q       <= mie_sw_d;
      mie_tim_q      <= mie_tim_d;
      mie_ext_q      <= mie_ext_d;
      mie_fast_q     <= mie_fast_d;
      mscratch_q     <= mscratch_d;
      mepc_q         <= mepc_d;
      mcause_q       <= mcause_d;
      mtval_q        <= mtval_d;
      mtvec_q        <= mtvec_d;
    end
  end

  assign csr_mtvec_o       = mtvec_q;
  assign csr_mepc_o        = mepc_q;
  assign csr_mstatus_mie_o = mstatus_mie_q;
  assign irq_pending_o     = |mip_word;

endmodule

// ==== design/perf_counters.sv ====
/*
 * Machine counters mcycle and minstret with their high halves,
 * and mcountinhibit.
 */
`timescale 1ns/1ps

module perf_counters
  import csr_pkg::*;
#(
  parameter int unsigned CounterWidth = 64
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    instr_ret_i,
  csr_bus_if.bank bus
);

  typedef logic [63:0] cnt_t;

  // bits above CounterWidth read as zero
  localparam cnt_t CntMask = cnt_t'((65'd1 << CounterWidth) - 65'd1);

  // index 0 is mcycle, index 1 is minstret
  cnt_t       cnt_q [2];
  cnt_t       cnt_d [2];
  logic [1:0] incr;
  logic [1:0] we_lo;
  logic [1:0] we_hi;
  logic [1:0] inhibit_q;
  logic       inhibit_we;

  // --------------------
  // address decode
  // --------------------
  always_comb begin
    bus.rdata  = '0;
    bus.hit    = 1'b1;
    we_lo      = '0;
    we_hi      = '0;
    inhibit_we = 1'b0;
    case (bus.addr)
      CSR_MCOUNTINHIBIT: begin
        bus.rdata  = {29'b0, inhibit_q[1], 1'b0, inhibit_q[0]};
        inhibit_we = bus.we;
      end
      CSR_MCYCLE: begin
        bus.rdata = cnt_q[0][31:0];
        we_lo[0]  = bus.we;
      end
      CSR_MCYCLEH: begin
        bus.rdata = cnt_q[0][63:32];
        we_hi[0]  = bus.we;
      end
      CSR_MINSTRET: begin
        bus.rdata = cnt_q[1][31:0];
        we_lo[1]  = bus.we;
      end
      CSR_MINSTRETH: begin
        bus.rdata = cnt_q[1][63:32];
        we_hi[1]  = bus.we;
      end
      default: bus.hit = 1'b0;
    endcase
  end

  assign incr[0] = ~inhibit_q[0];
  assign incr[1] = instr_ret_i & ~inhibit_q[1];

  // a write replaces the increment of that cycle
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (we_lo[i]) begin
        cnt_d[i] = CntMask & {cnt_q[i][63:32], bus.wdata};
      end else if (we_hi[i]) begin
        cnt_d[i] = CntMask & {bus.wdata, cnt_q[i][31:0]};
      end else if (incr[i]) begin
        cnt_d[i] = CntMask & (cnt_q[i] + 64'd1);
      end else begin
        cnt_d[i] = cnt_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
      cnt_q[0]  <= '0;
      cnt_q[1]  <= '0;
    end else begin
      // only ir and cy are writable
      if (inhibit_we) begin
        inhibit_q <= {bus.wdata[2], bus.wdata[0]};
      end
      cnt_q[0] <= cnt_d[0];
      cnt_q[1] <= cnt_d[1];
    end
  end

endmodule

// ==== design/csr_top.sv ====
/*
 * CSR block top level: access controller, trap bank and counter bank.
 */
`timescale 1ns/1ps

module csr_top
  import csr_pkg::*;
#(
  parameter int unsigned CounterWidth = 64
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  csr_data_t  hart_id_i,

  // csr access
  input  logic       csr_access_i,
  input  logic       instr_new_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_op_e    csr_op_i,
  input  csr_data_t  csr_wdata_i,
  output csr_data_t  csr_rdata_o,
  output logic       illegal_csr_o,

  // interrupts
  input  logic       irq_software_i,
  input  logic       irq_timer_i,
  input  logic       irq_external_i,
  input  irq_fast_t  irq_fast_i,
  output logic       irq_pending_o,

  // trap control
  input  logic       csr_mtvec_init_i,
  input  csr_data_t  boot_addr_i,
  input  logic       csr_save_cause_i,
  input  logic       csr_save_if_i,
  input  csr_data_t  pc_if_i,
  input  csr_data_t  pc_id_i,
  input  exc_cause_t csr_mcause_i,
  input  csr_data_t  csr_mtval_i,
  input  logic       csr_restore_mret_i,
  output csr_data_t  csr_mtvec_o,
  output csr_data_t  csr_mepc_o,
  output logic       csr_mstatus_mie_o,

  // counters
  input  logic       instr_ret_i
);

  csr_bus_if trap_bus ();
  csr_bus_if perf_bus ();

  csr_access_ctrl u_ctrl (
    .csr_access_i  (csr_access_i),
    .instr_new_i   (instr_new_i),
    .csr_addr_i    (csr_addr_i),
    .csr_op_i      (csr_op_i),
    .csr_wdata_i   (csr_wdata_i),
    .hart_id_i     (hart_id_i),
    .csr_rdata_o   (csr_rdata_o),
    .illegal_csr_o (illegal_csr_o),
    .trap_bus      (trap_bus.ctrl),
    .perf_bus      (perf_bus.ctrl)
  );

  trap_csrs u_trap (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .irq_software_i     (irq_software_i),
    .irq_timer_i        (irq_timer_i),
    .irq_external_i     (irq_external_i),
    .irq_fast_i         (irq_fast_i),
    .csr_mtvec_init_i   (csr_mtvec_init_i),
    .boot_addr_i        (boot_addr_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_mcause_i       (csr_mcause_i),
    .csr_mtval_i        (csr_mtval_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_mtvec_o        (csr_mtvec_o),
    .csr_mepc_o         (csr_mepc_o),
    .csr_mstatus_mie_o  (csr_mstatus_mie_o),
    .irq_pending_o      (irq_pending_o),
    .bus                (trap_bus.bank)
  );

  perf_counters #(
    .CounterWidth (CounterWidth)
  ) u_perf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_ret_i (instr_ret_i),
    .bus         (perf_bus.bank)
  );

endmodule

// ==== sim/csr_top_asserts.sv ====
/*
 * Concurrent assertions on the CSR block top level, bound to csr_top.
 */
`timescale 1ns/1ps

module csr_top_asserts
  import csr_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      csr_access_i,
  input logic      illegal_csr_o,
  input csr_data_t csr_mtvec_o,
  input csr_data_t csr_mepc_o
);

  int error_count = 0;

  // illegal only qualifies a real access
  illegal_needs_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
      illegal_csr_o |-> csr_access_i)
    else begin
      $error("illegal_csr_o high without csr_access_i");
      error_count++;
    end

  mtvec_mode_vectored: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_mtvec_o[1:0] == 2'b01)
    else begin
      $error("mtvec mode bits are not 01");
      error_count++;
    end

  mepc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_mepc_o[0] == 1'b0)
    else begin
      $error("mepc bit 0 is set");
      error_count++;
    end

endmodule

bind csr_top csr_top_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .csr_access_i  (csr_access_i),
  .illegal_csr_o (illegal_csr_o),
  .csr_mtvec_o   (csr_mtvec_o),
  .csr_mepc_o    (csr_mepc_o)
);

// ==== sim/tb_csr_top.sv ====
/*
 * Testbench for the CSR block: replays the golden operation file,
 * then checks mcycle and minstret with random write data.
 */
`timescale 1ns/1ps

module tb_csr_top
  import csr_pkg::*;
();

  logic       clk_i;
  logic       rst_ni;
  csr_data_t  hart_id_i;
  logic       csr_access_i;
  logic       instr_new_i;
  csr_addr_t  csr_addr_i;
  csr_op_e    csr_op_i;
  csr_data_t  csr_wdata_i;
  csr_data_t  csr_rdata_o;
  logic       illegal_csr_o;
  logic       irq_software_i;
  logic       irq_timer_i;
  logic       irq_external_i;
  irq_fast_t  irq_fast_i;
  logic       irq_pending_o;
  logic       csr_mtvec_init_i;
  csr_data_t  boot_addr_i;
  logic       csr_save_cause_i;
  logic       csr_save_if_i;
  csr_data_t  pc_if_i;
  csr_data_t  pc_id_i;
  exc_cause_t csr_mcause_i;
  csr_data_t  csr_mtval_i;
  logic       csr_restore_mret_i;
  csr_data_t  csr_mtvec_o;
  csr_data_t  csr_mepc_o;
  logic       csr_mstatus_mie_o;
  logic       instr_ret_i;

  csr_top #(
    .CounterWidth (64)
  ) dut (.*);

  always #20 clk_i = ~clk_i;

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "test stopped at the first failure");
  endtask

  task automatic check_data(input csr_data_t got, input csr_data_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s flag %b, expected %b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic drop_strobes();
    csr_access_i       = 1'b0;
    instr_new_i        = 1'b0;
    csr_op_i           = CSR_OP_READ;
    csr_save_cause_i   = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_mtvec_init_i   = 1'b0;
  endtask

  // one access, outputs sampled mid cycle, write lands on the next edge
  task automatic do_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t data,
                           output csr_data_t rdata, output logic ill);
    @(posedge clk_i);
    #2;
    csr_access_i = 1'b1;
    instr_new_i  = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = data;
    @(negedge clk_i);
    rdata = csr_rdata_o;
    ill   = illegal_csr_o;
    @(posedge clk_i);
    #2;
    drop_strobes();
  endtask

  task automatic apply_line(input string kind, input logic [31:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp,
                            input logic [31:0] flag, input int line_no);
    csr_data_t rdata;
    logic      ill;
    string     tag;
    tag = $sformatf("golden line %0d (%s %h)", line_no, kind, addr[11:0]);
    if (kind == "access") begin
      do_access(csr_op_e'(op[1:0]), addr[11:0], data, rdata, ill);
      check_data(rdata, exp, tag);
      check_flag(ill, flag[0], tag);
      // trap outputs follow the register read back
      if (op[1:0] == CSR_OP_READ && addr[11:0] == CSR_MTVEC) begin
        check_data(csr_mtvec_o, exp, {tag, " mtvec output"});
      end
      if (op[1:0] == CSR_OP_READ && addr[11:0] == CSR_MEPC) begin
        check_data(csr_mepc_o, exp, {tag, " mepc output"});
      end
    end else if (kind == "trap" || kind == "mret" || kind == "boot") begin
      @(posedge clk_i);
      #2;
      csr_save_cause_i   = (kind == "trap");
      csr_restore_mret_i = (kind == "mret");
      csr_mtvec_init_i   = (kind == "boot");
      boot_addr_i        = data;
      // pc_if differs so a wrong pc select shows in mepc
      pc_id_i            = data;
      pc_if_i            = ~data;
      csr_mcause_i       = addr[5:0];
      csr_mtval_i        = exp;
      @(posedge clk_i);
      #2;
      drop_strobes();
      if (kind != "boot") begin
        check_flag(csr_mstatus_mie_o, flag[0], tag);
      end
    end else if (kind == "irq") begin
      @(posedge clk_i);
      #2;
      irq_software_i = data[MSIX_BIT];
      irq_timer_i    = data[MTIX_BIT];
      irq_external_i = data[MEIX_BIT];
      irq_fast_i     = data[MFIX_HIGH:MFIX_LOW];
      @(negedge clk_i);
      check_flag(irq_pending_o, flag[0], tag);
    end else begin
      $display("unknown operation kind '%s' on golden line %0d", kind, line_no);
      stop_on_failure();
    end
  endtask

  // polls a counter until it shows the expected value
  task automatic wait_counter(input csr_addr_t addr, input csr_data_t exp, input int max_reads);
    csr_data_t rdata;
    logic      ill;
    int        n;
    n = 0;
    do_access(CSR_OP_READ, addr, '0, rdata, ill);
    while (rdata !== exp && n < max_reads) begin
      do_access(CSR_OP_READ, addr, '0, rdata, ill);
      n++;
    end
    if (rdata !== exp) begin
      $display("counter at %h did not reach %h within %0d reads", addr, exp, max_reads);
      stop_on_failure();
    end
  endtask

  task automatic run_counter_checks();
    csr_data_t   cyc_val;
    csr_data_t   cych_val;
    csr_data_t   ret_start;
    csr_data_t   rdata;
    logic        ill;
    int unsigned pulses;
    cyc_val   = $urandom();
    cych_val  = $urandom();
    // keep clear of a carry into minstreth
    ret_start = $urandom() & 32'h7fff_ffff;
    pulses    = 3 + ($urandom() % 6);

    // mcycle inhibited, minstret running
    do_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h1, rdata, ill);
    do_access(CSR_OP_WRITE, CSR_MCYCLE, cyc_val, rdata, ill);
    do_access(CSR_OP_WRITE, CSR_MCYCLEH, cych_val, rdata, ill);
    do_access(CSR_OP_READ, CSR_MCYCLE, '0, rdata, ill);
    check_data(rdata, cyc_val, "mcycle while inhibited");
    do_access(CSR_OP_READ, CSR_MCYCLEH, '0, rdata, ill);
    check_data(rdata, cych_val, "mcycleh read-back");
    do_access(CSR_OP_READ, CSR_MCOUNTINHIBIT, '0, rdata, ill);
    check_data(rdata, 32'h1, "mcountinhibit read-back");

    do_access(CSR_OP_WRITE, CSR_MINSTRET, ret_start, rdata, ill);
    do_access(CSR_OP_READ, CSR_MINSTRET, '0, rdata, ill);
    check_data(rdata, ret_start, "minstret start value");

    @(posedge clk_i);
    #2;
    instr_ret_i = 1'b1;
    repeat (pulses) @(posedge clk_i);
    #2;
    instr_ret_i = 1'b0;
    wait_counter(CSR_MINSTRET, ret_start + pulses, 16);
    do_access(CSR_OP_READ, CSR_MINSTRET, '0, rdata, ill);
    check_data(rdata, ret_start + pulses, "minstret after retire pulses");
    do_access(CSR_OP_READ, CSR_MINSTRETH, '0, rdata, ill);
    check_data(rdata, 32'h0, "minstreth without carry");
  endtask

  initial begin
    int          fd;
    int          n;
    int          line_no;
    string       line;
    string       kind;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    logic [31:0] f_flag;

    void'($urandom(32'h7202d463));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    hart_id_i      = 32'h0000_0005;
    csr_addr_i     = '0;
    csr_wdata_i    = '0;
    irq_software_i = 1'b0;
    irq_timer_i    = 1'b0;
    irq_external_i = 1'b0;
    irq_fast_i     = '0;
    boot_addr_i    = '0;
    csr_save_if_i  = 1'b0;
    pc_if_i        = '0;
    pc_id_i        = '0;
    csr_mcause_i   = '0;
    csr_mtval_i    = '0;
    instr_ret_i    = 1'b0;
    drop_strobes();

    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // --------------------
    // golden replay
    // --------------------
    fd = $fopen("sim/csr_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file sim/csr_golden.txt");
      stop_on_failure();
    end
    line_no = 0;
    while ($fgets(line, fd) > 0) begin
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h", kind, f_op, f_addr, f_data, f_exp, f_flag);
      if (n != 6) begin
        $display("golden line %0d is malformed", line_no);
        stop_on_failure();
      end
      apply_line(kind, f_op, f_addr, f_data, f_exp, f_flag, line_no);
    end
    $fclose(fd);

    run_counter_checks();

    if (dut.u_asserts.error_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures were reported", dut.u_asserts.error_count);
      stop_on_failure();
    end
  end

endmodule

// ==== sim/csr_golden.txt ====
# kind op addr data exp flag (hex); op 0 read 1 write 2 set 3 clear; access: exp=read value, flag=illegal
# trap: addr=cause data=pc exp=mtval flag=mie after; mret: flag=mie after; boot: data=boot addr; irq: data in mip layout, flag=pending
access 1 340 a5a5f00f 00000000 0
access 2 340 00000ff0 a5a5f00f 0
access 3 340 a5000000 a5a5ffff 0
access 0 340 00000000 00a5ffff 0
access 1 304 ffffffff 00000000 0
access 3 304 00000080 7fff0888 0
access 0 304 00000000 7fff0808 0
access 0 f14 00000000 00000005 0
access 0 301 00000000 40000104 0
access 0 7c0 00000000 00000000 1
access 1 f14 12345678 00000005 1
access 0 f14 00000000 00000005 0
access 1 341 80001235 00000000 0
access 0 341 00000000 80001234 0
access 1 305 12345677 00000001 0
access 0 305 00000000 12345601 0
access 1 342 ffffffff 00000000 0
access 0 342 00000000 8000001f 0
boot 0 000 20000180 00000000 0
access 0 305 00000000 20000101 0
access 2 300 00000008 00000080 0
trap 0 00b 80000103 deadbeef 0
access 0 341 00000000 80000102 0
access 0 342 00000000 0000000b 0
access 0 343 00000000 deadbeef 0
access 0 300 00000000 00000080 0
mret 0 000 00000000 00000000 1
access 0 300 00000000 00000088 0
access 1 304 00000000 7fff0808 0
irq 0 000 00000880 00000000 0
access 0 344 00000000 00000000 0
access 1 304 00000800 00000000 0
access 0 344 00000000 00000800 0
irq 0 000 00000880 00000000 1
irq 0 000 00010000 00000000 0
irq 0 000 00000000 00000000 0

// ==== csr_regfile.f ====
design/csr_pkg.sv
design/csr_bus_if.sv
design/csr_access_ctrl.sv
design/trap_csrs.sv
design/perf_counters.sv
design/csr_top.sv
sim/csr_top_asserts.sv
sim/tb_csr_top.sv

// ==== Bender.yml ====
package:
  name: csr_regfile

sources:
  - design/csr_pkg.sv
  - design/csr_bus_if.sv
  - design/csr_access_ctrl.sv
  - design/trap_csrs.sv
  - design/perf_counters.sv
  - design/csr_top.sv
  - target: simulation
    files:
      - sim/csr_top_asserts.sv
      - sim/tb_csr_top.sv
